/* logic/msr_map_pkg.sv */
// MSR address map shared by the execute and commit sides; import where bank decode or widths are needed
package msr_map_pkg;

   // Data path and PC widths
   localparam int data_w = 32;
   localparam int pc_w = 30;

   // Significant PSR bits, the rest of the word reads as zero
   localparam int psr_w = 10;

   // MSR address fields
   localparam int bank_aw = 5;
   localparam int off_aw = 9;

   // Bank codes, taken from address bits 13..9
   localparam logic [bank_aw-1:0] bank_ps = 5'd0;
   localparam logic [bank_aw-1:0] bank_irqc = 5'd6;
   localparam logic [bank_aw-1:0] bank_tsc = 5'd7;

   // Processor-state bank, one-hot offset bits
   localparam int off_psr = 0;
   localparam int off_cpuid = 1;
   localparam int off_epsr = 2;
   localparam int off_epc = 3;
   localparam int off_elsa = 4;
   localparam int off_coreid = 5;

   // Interrupt controller bank
   localparam int off_imr = 0;
   localparam int off_irr = 1;

   // Timestamp counter bank
   localparam int off_tsr = 0;
   localparam int off_tcr = 1;

   // TCR layout
   localparam int tcr_cnt_w = 28;
   localparam int tcr_en = 28;
   localparam int tcr_ie = 29;
   localparam int tcr_p = 30;

   // Write enables handed from execute to commit
   typedef struct packed {
      logic psr;
      logic epc;
      logic epsr;
      logic elsa;
      logic imr;
      logic tsr;
      logic tcr;
      logic [off_aw-1:0] bank_off;
   } wmsr_we_t;

endpackage

/* logic/exc_pkg.sv */
// Exception flags, PSR layout, vectors and the stage structs used across the exception unit
package exc_pkg;

   import msr_map_pkg::*;

   // Exception sources as seen at commit
   typedef struct packed {
      logic eret;
      logic esyscall;
      logic einsn;
      logic eipf;
      logic eitm;
      logic eirq;
      logic edtm;
      logic edpf;
      logic ealign;
      logic flush_tlb;
   } exc_flags_t;

   // One-hot opcode from the issue stage
   typedef struct packed {
      logic eret;
      logic esyscall;
      logic einsn;
      logic eipf;
      logic eitm;
      logic eirq;
      logic wmsr;
   } epu_opc_t;

   // PSR fields, top down
   typedef struct packed {
      logic [21:0] rsvd;
      logic [1:0]  res_hi;
      logic        dmme;
      logic        imme;
      logic        ire;
      logic        rm;
      logic [3:0]  res_lo;
   } psr_t;

   // Raw word for EPC and ELSA, field view for PSR
   typedef union packed {
      logic [data_w-1:0] word;
      psr_t              psr;
   } psr_word_u;

   // Exception vectors, word addresses
   localparam logic [pc_w-1:0] vec_eitm = 30'd1;
   localparam logic [pc_w-1:0] vec_eipf = 30'd2;
   localparam logic [pc_w-1:0] vec_esyscall = 30'd3;
   localparam logic [pc_w-1:0] vec_einsn = 30'd4;
   localparam logic [pc_w-1:0] vec_eirq = 30'd5;
   localparam logic [pc_w-1:0] vec_edtm = 30'd6;
   localparam logic [pc_w-1:0] vec_edpf = 30'd7;
   localparam logic [pc_w-1:0] vec_ealign = 30'd8;

   typedef struct packed {
      logic              valid;
      epu_opc_t          opc;
      logic [data_w-1:0] operand1;
      logic [data_w-1:0] operand2;
      logic [data_w-1:0] imm;
   } ex_req_t;

   typedef struct packed {
      exc_flags_t        exc;
      logic [pc_w-1:0]   epc;
      logic [pc_w-1:0]   nepc;
      logic [data_w-1:0] lsa;
      wmsr_we_t          wmsr_we;
      psr_word_u         wmsr_dat;
   } commit_t;

   typedef struct packed {
      logic [data_w-1:0] dout;
      logic [data_w-1:0] wmsr_dat;
      wmsr_we_t          wmsr_we;
      exc_flags_t        strobes;
   } epu_result_t;

   typedef struct packed {
      logic rm;
      logic imme;
      logic dmme;
      logic ire;
      logic we;
   } psr_upd_t;

endpackage

/* logic/msr_decode.sv */
// Execute-side MSR decode; forms read data, write enables and exception strobes in one cycle
`timescale 1ns/1ps

module msr_decode
   import msr_map_pkg::*, exc_pkg::*;
(
   input  ex_req_t           ex,
   input  psr_word_u         msr_psr,
   input  psr_word_u         msr_epsr,
   input  logic [data_w-1:0] msr_epc,
   input  logic [data_w-1:0] msr_elsa,
   input  logic [data_w-1:0] msr_cpuid,
   input  logic [data_w-1:0] msr_coreid,
   input  logic [data_w-1:0] imr,
   input  logic [data_w-1:0] irr,
   input  logic [data_w-1:0] tsr,
   input  logic [data_w-1:0] tcr,
   output epu_result_t       result
);

   logic [data_w-1:0]  msr_addr;
   logic [bank_aw-1:0] bank;
   logic [off_aw-1:0]  off;
   logic               sel_ps;
   logic               sel_irqc;
   logic               sel_tsc;
   logic               wmsr;
   logic [data_w-1:0]  psr_ext;
   logic [data_w-1:0]  epsr_ext;
   logic [data_w-1:0]  dout_ps;
   logic [data_w-1:0]  dout_irqc;
   logic [data_w-1:0]  dout_tsc;
   wmsr_we_t           we;

   // Address is the register operand OR-ed with a 15-bit immediate
   assign msr_addr = ex.operand1 | {{(data_w-15){1'b0}}, ex.imm[14:0]};
   assign bank = msr_addr[bank_aw+off_aw-1:off_aw];
   assign off = msr_addr[off_aw-1:0];

   assign sel_ps = (bank == bank_ps);
   assign sel_irqc = (bank == bank_irqc);
   assign sel_tsc = (bank == bank_tsc);

   assign psr_ext = {{(data_w-psr_w){1'b0}}, msr_psr.word[psr_w-1:0]};
   assign epsr_ext = {{(data_w-psr_w){1'b0}}, msr_epsr.word[psr_w-1:0]};

   // One-hot offsets allow a plain AND-OR mux
   assign dout_ps = ({data_w{off[off_psr]}} & psr_ext) |
                    ({data_w{off[off_cpuid]}} & msr_cpuid) |
                    ({data_w{off[off_epsr]}} & epsr_ext) |
                    ({data_w{off[off_epc]}} & msr_epc) |
                    ({data_w{off[off_elsa]}} & msr_elsa) |
                    ({data_w{off[off_coreid]}} & msr_coreid);

   assign dout_irqc = ({data_w{off[off_imr]}} & imr) |
                      ({data_w{off[off_irr]}} & irr);

   assign dout_tsc = ({data_w{off[off_tsr]}} & tsr) |
                     ({data_w{off[off_tcr]}} & tcr);

   assign wmsr = ex.valid & ex.opc.wmsr;

   always_comb begin
      we = '0;
      we.psr = wmsr & sel_ps & off[off_psr];
      we.epc = wmsr & sel_ps & off[off_epc];
      we.epsr = wmsr & sel_ps & off[off_epsr];
      we.elsa = wmsr & sel_ps & off[off_elsa];
      we.imr = wmsr & sel_irqc & off[off_imr];
      we.tsr = wmsr & sel_tsc & off[off_tsr];
      we.tcr = wmsr & sel_tsc & off[off_tcr];
      we.bank_off = off;
   end

   always_comb begin
      result = '0;
      // Unknown banks fall through as zero
      result.dout = ({data_w{sel_ps}} & dout_ps) |
                    ({data_w{sel_irqc}} & dout_irqc) |
                    ({data_w{sel_tsc}} & dout_tsc);
      result.wmsr_dat = ex.operand2;
      result.wmsr_we = we;
      result.strobes.eret = ex.valid & ex.opc.eret;
      result.strobes.esyscall = ex.valid & ex.opc.esyscall;
      result.strobes.einsn = ex.valid & ex.opc.einsn;
      result.strobes.eipf = ex.valid & ex.opc.eipf;
      result.strobes.eitm = ex.valid & ex.opc.eitm;
      result.strobes.eirq = ex.valid & ex.opc.eirq;
      // PSR write may change MMU enables
      result.strobes.flush_tlb = we.psr;
   end

endmodule

/* logic/exc_commit.sv */
// Commit-side exception handling; computes PSR/EPSR/EPC/ELSA updates and the pipeline flush target
`timescale 1ns/1ps

module exc_commit
   import msr_map_pkg::*, exc_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  commit_t           commit,
   input  psr_word_u         msr_psr,
   input  psr_word_u         msr_epsr,
   input  logic [data_w-1:0] msr_epc,
   output psr_upd_t          psr_upd,
   output psr_word_u         epsr_nxt,
   output logic              epsr_we,
   output logic [data_w-1:0] epc_nxt,
   output logic              epc_we,
   output logic [data_w-1:0] elsa_nxt,
   output logic              elsa_we,
   output logic              exc_ent,
   output logic              exc_flush,
   output logic [pc_w-1:0]   exc_flush_tgt
);

   exc_flags_t exc;
   wmsr_we_t   we;
   psr_word_u  wdat;
   psr_t       psr_src;
   logic       exc_ent_q;
   logic       save_psr;
   logic       elsa_as_pc;
   logic       elsa_set;

   assign exc = commit.exc;
   assign we = commit.wmsr_we;
   assign wdat = commit.wmsr_dat;

   // Entry into a handler, ERET and TLB flush excluded
   assign exc_ent = exc.esyscall | exc.einsn | exc.eipf | exc.eitm | exc.eirq |
                    exc.edtm | exc.edpf | exc.ealign;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         exc_ent_q <= 1'b0;
      end else begin
         exc_ent_q <= exc_ent;
      end
   end

   // Only the first cycle of a held exception saves PSR
   assign save_psr = exc_ent & ~exc_ent_q;

   // PSR restore on ERET, or direct write
   assign psr_src = we.psr ? wdat.psr : msr_epsr.psr;
   assign psr_upd.we = we.psr | exc.eret;
   assign psr_upd.rm = psr_src.rm;
   assign psr_upd.imme = psr_src.imme;
   assign psr_upd.dmme = psr_src.dmme;
   assign psr_upd.ire = psr_src.ire;

   assign epsr_we = we.epsr | save_psr;
   assign epsr_nxt = we.epsr ? wdat : msr_psr;

   // Syscall returns past itself, other faults retry the insn
   assign epc_we = exc_ent | we.epc;
   assign epc_nxt = we.epc ? wdat.word :
                    exc.esyscall ? {commit.nepc, 2'b00} : {commit.epc, 2'b00};

   // Fetch-side faults report the PC as the faulting address
   assign elsa_as_pc = exc.eitm | exc.eipf | exc.einsn;
   assign elsa_set = elsa_as_pc | exc.edtm | exc.edpf | exc.ealign;
   assign elsa_we = elsa_set | we.elsa;
   assign elsa_nxt = elsa_as_pc ? {commit.epc, 2'b00} :
                     elsa_set ? commit.lsa : wdat.word;

   assign exc_flush = |exc;

   // Flags are mutually exclusive at commit
   assign exc_flush_tgt = ({pc_w{exc.edtm}} & vec_edtm) |
                          ({pc_w{exc.edpf}} & vec_edpf) |
                          ({pc_w{exc.ealign}} & vec_ealign) |
                          ({pc_w{exc.esyscall}} & vec_esyscall) |
                          ({pc_w{exc.eitm}} & vec_eitm) |
                          ({pc_w{exc.eipf}} & vec_eipf) |
                          ({pc_w{exc.eirq}} & vec_eirq) |
                          ({pc_w{exc.einsn}} & vec_einsn) |
                          ({pc_w{exc.eret}} & msr_epc[data_w-1:2]) |
                          ({pc_w{exc.flush_tlb}} & commit.nepc);

endmodule

/* logic/irq_ctrl.sv */
// Interrupt controller with mask and request registers; feeds the asynchronous interrupt line
`timescale 1ns/1ps

module irq_ctrl
   import msr_map_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic [data_w-1:0] irqs,
   input  logic              ire,
   input  logic              imr_we,
   input  logic [data_w-1:0] wdat,
   output logic [data_w-1:0] imr,
   output logic [data_w-1:0] irr,
   output logic              irq_async
);

   // All sources masked out of reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         imr <= '1;
         irr <= '0;
      end else begin
         if (imr_we) begin
            imr <= wdat;
         end
         irr <= irqs & ~imr;
      end
   end

   // Any pending request while interrupts are enabled
   assign irq_async = (|irr) & ire;

endmodule

/* logic/tsc_timer.sv */
// Timestamp counter with a compare interrupt; TSR and TCR are written from commit
`timescale 1ns/1ps

module tsc_timer
   import msr_map_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              tsr_we,
   input  logic              tcr_we,
   input  logic [data_w-1:0] wdat,
   output logic [data_w-1:0] tsr,
   output logic [data_w-1:0] tcr,
   output logic              tsc_irq
);

   logic hit;

   // Compare on the low counter bits only
   assign hit = tcr[tcr_en] & (tsr[tcr_cnt_w-1:0] == tcr[tcr_cnt_w-1:0]);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tsr <= '0;
      end else if (tsr_we) begin
         tsr <= wdat;
      end else if (tcr[tcr_en]) begin
         tsr <= tsr + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tcr <= '0;
      end else if (tcr_we) begin
         tcr <= wdat;
         // Writing TCR acknowledges the interrupt
         tcr[tcr_p] <= 1'b0;
      end else if (hit) begin
         tcr[tcr_p] <= 1'b1;
      end
   end

   assign tsc_irq = tcr[tcr_p] & tcr[tcr_ie];

endmodule

/* logic/epu_top.sv */
// Exception processing unit top; connects MSR decode, commit logic, interrupt controller and timer
`timescale 1ns/1ps

module epu_top
   import msr_map_pkg::*, exc_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  ex_req_t           ex,
   input  commit_t           commit,
   input  logic [data_w-1:0] irqs,
   input  psr_word_u         msr_psr,
   input  psr_word_u         msr_epsr,
   input  logic [data_w-1:0] msr_epc,
   input  logic [data_w-1:0] msr_elsa,
   input  logic [data_w-1:0] msr_cpuid,
   input  logic [data_w-1:0] msr_coreid,
   output epu_result_t       result,
   output psr_upd_t          psr_upd,
   output psr_word_u         epsr_nxt,
   output logic              epsr_we,
   output logic [data_w-1:0] epc_nxt,
   output logic              epc_we,
   output logic [data_w-1:0] elsa_nxt,
   output logic              elsa_we,
   output logic              exc_ent,
   output logic              exc_flush,
   output logic [pc_w-1:0]   exc_flush_tgt,
   output logic              irq_async,
   output logic              tsc_irq
);

   logic [data_w-1:0] imr;
   logic [data_w-1:0] irr;
   logic [data_w-1:0] tsr;
   logic [data_w-1:0] tcr;

   msr_decode u_msr_decode (
      .ex         (ex),
      .msr_psr    (msr_psr),
      .msr_epsr   (msr_epsr),
      .msr_epc    (msr_epc),
      .msr_elsa   (msr_elsa),
      .msr_cpuid  (msr_cpuid),
      .msr_coreid (msr_coreid),
      .imr        (imr),
      .irr        (irr),
      .tsr        (tsr),
      .tcr        (tcr),
      .result     (result)
   );

   exc_commit u_exc_commit (
      .clk           (clk),
      .rst_n         (rst_n),
      .commit        (commit),
      .msr_psr       (msr_psr),
      .msr_epsr      (msr_epsr),
      .msr_epc       (msr_epc),
      .psr_upd       (psr_upd),
      .epsr_nxt      (epsr_nxt),
      .epsr_we       (epsr_we),
      .epc_nxt       (epc_nxt),
      .epc_we        (epc_we),
      .elsa_nxt      (elsa_nxt),
      .elsa_we       (elsa_we),
      .exc_ent       (exc_ent),
      .exc_flush     (exc_flush),
      .exc_flush_tgt (exc_flush_tgt)
   );

   // Sub-units are written from the commit stage
   irq_ctrl u_irq_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .irqs      (irqs),
      .ire       (msr_psr.psr.ire),
      .imr_we    (commit.wmsr_we.imr),
      .wdat      (commit.wmsr_dat.word),
      .imr       (imr),
      .irr       (irr),
      .irq_async (irq_async)
   );

   tsc_timer u_tsc_timer (
      .clk     (clk),
      .rst_n   (rst_n),
      .tsr_we  (commit.wmsr_we.tsr),
      .tcr_we  (commit.wmsr_we.tcr),
      .wdat    (commit.wmsr_dat.word),
      .tsr     (tsr),
      .tcr     (tcr),
      .tsc_irq (tsc_irq)
   );

endmodule

/* test/tb_clock.sv */
// Free-running clock for the testbench, instantiated once by the testbench top
`timescale 1ns/1ps

module tb_clock (
   output logic clk
);

   // 40 ns period
   initial begin
      clk = 1'b0;
      forever begin
         #20 clk = ~clk;
      end
   end

endmodule

/* test/tb_epu.sv */
// Testbench for the exception unit; drives execute and commit inputs and asserts on every response
`timescale 1ns/1ps

module tb_epu
   import msr_map_pkg::*, exc_pkg::*;
();

   localparam int test_cycles = 120;
   localparam int clk_period = 40;
   localparam int tsc_cnt = 6;

   logic              clk;
   logic              rst_n;
   ex_req_t           ex;
   commit_t           commit;
   logic [data_w-1:0] irqs;
   psr_word_u         msr_psr;
   psr_word_u         msr_epsr;
   logic [data_w-1:0] msr_epc;
   logic [data_w-1:0] msr_elsa;
   logic [data_w-1:0] msr_cpuid;
   logic [data_w-1:0] msr_coreid;
   epu_result_t       result;
   psr_upd_t          psr_upd;
   psr_word_u         epsr_nxt;
   logic              epsr_we;
   logic [data_w-1:0] epc_nxt;
   logic              epc_we;
   logic [data_w-1:0] elsa_nxt;
   logic              elsa_we;
   logic              exc_ent;
   logic              exc_flush;
   logic [pc_w-1:0]   exc_flush_tgt;
   logic              irq_async;
   logic              tsc_irq;

   integer seed = 32'h736e;

   tb_clock u_tb_clock (
      .clk (clk)
   );

   epu_top u_epu_top (.*);

   function automatic logic [31:0] rnd();
      return $random(seed);
   endfunction

   // PSR fields in psr_upd order {rm, imme, dmme, ire}
   function automatic logic [3:0] psr_fields(input logic [31:0] v);
      return {v[4], v[6], v[7], v[5]};
   endfunction

   // Handler entry indexed by bit position in the exception flags
   function automatic logic [29:0] handler_vector(input int pos);
      case (pos)
         8: return 30'd3;
         7: return 30'd4;
         6: return 30'd2;
         5: return 30'd1;
         4: return 30'd5;
         3: return 30'd6;
         2: return 30'd7;
         1: return 30'd8;
         default: return 30'd0;
      endcase
   endfunction

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("SIMULATION FAILED");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
      assert (got === want) else begin
         stop_on_error($sformatf("error at %0t ns: %s is %h, expected %h",
                                 $time, name, got, want));
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   // Outputs are stable well before the next edge
   task automatic sample();
      #30;
   endtask

   // Spread the MSR address over operand1 and the immediate
   task automatic set_addr(input logic [4:0] bank, input logic [8:0] off);
      logic [31:0] r;
      logic [14:0] addr;
      r = rnd();
      addr = {1'b0, bank, off};
      ex.operand1 = {r[31:15], addr & r[14:0]};
      ex.imm = {~r[31:15], addr};
   endtask

   task automatic read_expect(input logic [4:0] bank, input logic [8:0] off,
                              input logic [31:0] want);
      next_cycle();
      commit = '0;
      ex.valid = 1'b0;
      ex.opc = '0;
      set_addr(bank, off);
      sample();
      check("result.dout", result.dout, want);
   endtask

   initial begin
      logic [31:0] exp;
      logic [31:0] mask;
      logic [31:0] val;
      logic [31:0] t1;
      logic [4:0]  bank;
      wmsr_we_t    exp_we;
      logic        ent;
      logic        seen;
      int          w_bank [7];
      int          w_off [7];

      rst_n = 1'b0;
      ex = '0;
      commit = '0;
      irqs = '0;
      msr_psr = '0;
      msr_epsr = '0;
      msr_epc = '0;
      msr_elsa = '0;
      msr_cpuid = '0;
      msr_coreid = '0;
      repeat (5) @(posedge clk);
      #2;
      rst_n = 1'b1;

      // Processor-state bank read-out
      msr_psr.word = rnd();
      msr_epsr.word = rnd();
      msr_epc = rnd();
      msr_elsa = rnd();
      msr_cpuid = rnd();
      msr_coreid = rnd();
      for (int i = 0; i < 6; i++) begin
         case (i)
            0: exp = {22'b0, msr_psr.word[9:0]};
            1: exp = msr_cpuid;
            2: exp = {22'b0, msr_epsr.word[9:0]};
            3: exp = msr_epc;
            4: exp = msr_elsa;
            default: exp = msr_coreid;
         endcase
         read_expect(5'd0, 9'(1 << i), exp);
      end

      // Sub-unit registers straight out of reset
      read_expect(5'd6, 9'h001, 32'hffff_ffff);
      read_expect(5'd6, 9'h002, 32'h0);
      read_expect(5'd7, 9'h001, 32'h0);
      read_expect(5'd7, 9'h002, 32'h0);

      // Unmapped banks
      for (int i = 0; i < 6; i++) begin
         bank = 5'(rnd());
         if (bank == 5'd0 || bank == 5'd6 || bank == 5'd7) begin
            bank = bank + 5'd8;
         end
         read_expect(bank, 9'(rnd()), 32'h0);
      end

      // Write decode in wmsr_we field order psr epc epsr elsa imr tsr tcr
      w_bank = '{0, 0, 0, 0, 6, 7, 7};
      w_off = '{0, 3, 2, 4, 0, 0, 1};
      for (int r = 0; r < 7; r++) begin
         next_cycle();
         ex.valid = 1'b1;
         ex.opc = 7'b0000001;
         ex.operand2 = rnd();
         set_addr(5'(w_bank[r]), 9'(1 << w_off[r]));
         exp_we = {7'b1000000 >> r, 9'(1 << w_off[r])};
         sample();
         check("result.wmsr_we", 32'(result.wmsr_we), 32'(exp_we));
         check("result.wmsr_dat", result.wmsr_dat, ex.operand2);
         check("result.strobes", 32'(result.strobes), (r == 0) ? 32'h1 : 32'h0);
         next_cycle();
         ex.valid = 1'b0;
         sample();
         check("result.wmsr_we enables", 32'(result.wmsr_we[15:9]), 32'h0);
         check("result.strobes", 32'(result.strobes), 32'h0);
      end

      // Exception opcodes with and without valid
      for (int i = 1; i < 7; i++) begin
         for (int v = 0; v < 2; v++) begin
            next_cycle();
            ex.valid = v[0];
            ex.opc = 7'(1 << i);
            sample();
            exp = (v == 1) ? {22'b0, ex.opc[6:1], 4'b0} : 32'h0;
            check("result.strobes", 32'(result.strobes), exp);
         end
      end

      // Each exception at commit with eret first
      for (int b = 9; b > 0; b--) begin
         next_cycle();
         ex = '0;
         commit = '0;
         commit.exc = 10'(1 << b);
         commit.epc = 30'(rnd());
         commit.nepc = 30'(rnd());
         commit.lsa = rnd();
         msr_epc = rnd();
         msr_psr.word = rnd();
         msr_epsr.word = rnd();
         ent = (b != 9);
         sample();
         check("exc_flush", 32'(exc_flush), 32'h1);
         check("exc_flush_tgt", 32'(exc_flush_tgt),
               32'((b == 9) ? msr_epc[31:2] : handler_vector(b)));
         check("exc_ent", 32'(exc_ent), 32'(ent));
         check("epc_we", 32'(epc_we), 32'(ent));
         check("epsr_we", 32'(epsr_we), 32'(ent));
         if (ent) begin
            exp = (b == 8) ? {commit.nepc, 2'b00} : {commit.epc, 2'b00};
            check("epc_nxt", epc_nxt, exp);
            check("epsr_nxt", epsr_nxt.word, msr_psr.word);
            check("psr_upd.we", 32'(psr_upd.we), 32'h0);
         end else begin
            check("psr_upd", 32'(psr_upd), 32'({psr_fields(msr_epsr.word), 1'b1}));
         end
         // Fetch faults report the PC and data faults the access address
         if (b >= 5 && b <= 7) begin
            check("elsa_we", 32'(elsa_we), 32'h1);
            check("elsa_nxt", elsa_nxt, {commit.epc, 2'b00});
         end else if (b >= 1 && b <= 3) begin
            check("elsa_we", 32'(elsa_we), 32'h1);
            check("elsa_nxt", elsa_nxt, commit.lsa);
         end else begin
            check("elsa_we", 32'(elsa_we), 32'h0);
         end
         // Held a second cycle
         next_cycle();
         sample();
         check("epsr_we", 32'(epsr_we), 32'h0);
         next_cycle();
         commit = '0;
      end

      // PSR write with its TLB flush
      next_cycle();
      commit = '0;
      commit.exc.flush_tlb = 1'b1;
      commit.wmsr_we.psr = 1'b1;
      commit.wmsr_dat.word = rnd();
      commit.nepc = 30'(rnd());
      msr_epsr.word = ~commit.wmsr_dat.word;
      sample();
      check("psr_upd", 32'(psr_upd), 32'({psr_fields(commit.wmsr_dat.word), 1'b1}));
      check("exc_flush", 32'(exc_flush), 32'h1);
      check("exc_flush_tgt", 32'(exc_flush_tgt), 32'(commit.nepc));
      check("exc_ent", 32'(exc_ent), 32'h0);

      // Direct writes to EPSR, EPC and ELSA
      next_cycle();
      commit = '0;
      commit.wmsr_we.epsr = 1'b1;
      commit.wmsr_we.epc = 1'b1;
      commit.wmsr_we.elsa = 1'b1;
      commit.wmsr_dat.word = rnd();
      sample();
      check("epsr_we", 32'(epsr_we), 32'h1);
      check("epsr_nxt", epsr_nxt.word, commit.wmsr_dat.word);
      check("epc_we", 32'(epc_we), 32'h1);
      check("epc_nxt", epc_nxt, commit.wmsr_dat.word);
      check("elsa_we", 32'(elsa_we), 32'h1);
      check("elsa_nxt", elsa_nxt, commit.wmsr_dat.word);
      check("exc_flush", 32'(exc_flush), 32'h0);

      // Interrupt controller with bit 0 always unmasked and requested
      mask = rnd() & 32'hffff_fffe;
      val = rnd() | 32'h1;
      next_cycle();
      commit = '0;
      commit.wmsr_we.imr = 1'b1;
      commit.wmsr_dat.word = mask;
      irqs = val;
      msr_psr.word = '0;
      msr_psr.psr.ire = 1'b1;
      sample();
      check("irq_async", 32'(irq_async), 32'h0);
      read_expect(5'd6, 9'h001, mask);
      read_expect(5'd6, 9'h002, val & ~mask);
      check("irq_async", 32'(irq_async), 32'h1);
      next_cycle();
      msr_psr.psr.ire = 1'b0;
      sample();
      check("irq_async", 32'(irq_async), 32'h0);

      // Free-running counter with the compare value out of reach
      next_cycle();
      commit = '0;
      commit.wmsr_we.tcr = 1'b1;
      commit.wmsr_dat.word = 32'h1fff_ffff;
      irqs = '0;
      read_expect(5'd7, 9'h002, 32'h1fff_ffff);
      next_cycle();
      set_addr(5'd7, 9'h001);
      sample();
      t1 = result.dout;
      repeat (5) next_cycle();
      sample();
      check("tsr delta", result.dout - t1, 32'd5);

      // Compare interrupt with a small count
      next_cycle();
      commit = '0;
      commit.wmsr_we.tsr = 1'b1;
      commit.wmsr_dat.word = 32'h0;
      next_cycle();
      commit = '0;
      commit.wmsr_we.tcr = 1'b1;
      commit.wmsr_dat.word = 32'h3000_0000 | 32'(tsc_cnt);
      seen = 1'b0;
      for (int n = 0; n < tsc_cnt + 2 && !seen; n++) begin
         next_cycle();
         commit = '0;
         sample();
         seen = tsc_irq;
      end
      assert (seen) else stop_on_error("tsc_irq did not rise within cnt plus 2 cycles");
      // Pending bit set in the write data still clears
      next_cycle();
      commit = '0;
      commit.wmsr_we.tcr = 1'b1;
      commit.wmsr_dat.word = 32'h6000_0000;
      next_cycle();
      commit = '0;
      sample();
      check("tsc_irq", 32'(tsc_irq), 32'h0);

      next_cycle();
      $display("SIMULATION PASSED");
      $finish;
   end

   // Watchdog
   initial begin
      #((test_cycles + 200) * clk_period);
      stop_on_error("watchdog timeout, the tests did not finish in time");
   end

endmodule

/* verilog.f */
logic/msr_map_pkg.sv
logic/exc_pkg.sv
logic/msr_decode.sv
logic/exc_commit.sv
logic/irq_ctrl.sv
logic/tsc_timer.sv
logic/epu_top.sv
test/tb_clock.sv
test/tb_epu.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run the testbench, and judge the result from the log
rm -rf obj_dir sim.log
verilator --binary --assert --timing --top-module tb_epu -f verilog.f -o sim_epu || exit 1
./obj_dir/sim_epu > sim.log 2>&1
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0
